/* aluUnit.sv */
module aluUnit (
    input  datapathPkg::dataWord yValue,
    input  datapathPkg::dataWord busValue,
    input  datapathPkg::aluOp    op,
    input  logic                 incPc,
    output datapathPkg::wideWord result
);
    import datapathPkg::*;

    dataWord            addA;
    dataWord            addB;
    logic               carryIn;
    dataWord            sum;
    logic signed [63:0] yWide;
    logic signed [63:0] busWide;
    wideWord            product;
    logic               divOverflow;
    dataWord            quotient;
    dataWord            remainder;

    // one adder for add, sub and the pc increment
    assign addA    = incPc ? busValue : yValue;
    assign addB    = incPc ? 32'd1 : ((op == opSub) ? ~busValue : busValue);
    assign carryIn = !incPc && (op == opSub);   // two's complement for sub
    assign sum     = addA + addB + {31'd0, carryIn};

    // signed 64-bit product
    assign yWide   = {{32{yValue[31]}}, yValue};
    assign busWide = {{32{busValue[31]}}, busValue};
    assign product = yWide * busWide;

    // signed divide, y is the dividend and the bus the divisor
    assign divOverflow = (yValue == 32'h8000_0000) && (busValue == 32'hffff_ffff);

    always_comb begin
        if (busValue == '0) begin
            quotient  = '1;       // divide by zero
            remainder = yValue;
        end else if (divOverflow) begin
            quotient  = yValue;   // wraps back to the most negative value
            remainder = '0;
        end else begin
            quotient  = dataWord'($signed(yValue) / $signed(busValue));
            remainder = dataWord'($signed(yValue) % $signed(busValue));   // sign of dividend
        end
    end

    always_comb begin
        if (incPc) begin
            result = {32'd0, sum};   // pc + 1 regardless of op
        end else begin
            case (op)
                opAdd, opSub: begin
                    result = {32'd0, sum};
                end
                opAnd: begin
                    result = {32'd0, yValue & busValue};
                end
                opOr: begin
                    result = {32'd0, yValue | busValue};
                end
                opShl: begin
                    result = {32'd0, busValue << yValue[4:0]};
                end
                opShr: begin
                    result = {32'd0, busValue >> yValue[4:0]};   // logical
                end
                opNeg: begin
                    result = {32'd0, 32'd0 - busValue};
                end
                opNot: begin
                    result = {32'd0, ~busValue};
                end
                opMul: begin
                    result = product;
                end
                opDiv: begin
                    result = {remainder, quotient};   // hi gets remainder
                end
                default: begin
                    result = '0;   // nop
                end
            endcase
        end
    end

endmodule

/* datapathPkg.sv */
package datapathPkg;

    typedef logic [31:0] dataWord;   // one bus value
    typedef logic [63:0] wideWord;   // alu result, z register
    typedef logic [3:0]  regIndex;   // r0 .. r15

    // alu opcodes, same numbering as the instruction opcode field
    typedef enum logic [4:0] {
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opAnd = 5'b00101,
        opOr  = 5'b00110,
        opShr = 5'b00111,
        opShl = 5'b01001,
        opNop = 5'b01101,
        opMul = 5'b01111,
        opDiv = 5'b10000,
        opNeg = 5'b10001,
        opNot = 5'b10010
    } aluOp;

    typedef enum logic [3:0] {
        srcNone   = 4'd0,   // bus reads zero
        srcReg    = 4'd1,   // general register at regSelect
        srcPc     = 4'd2,
        srcMdr    = 4'd3,
        srcZLow   = 4'd4,
        srcZHigh  = 4'd5,
        srcHi     = 4'd6,
        srcLo     = 4'd7,
        srcInPort = 4'd8
    } busSource;

    // one control word per clock
    typedef struct packed {
        busSource source;      // the single bus driver
        regIndex  regSelect;   // register for both read and write
        logic     regIn;
        logic     pcIn;
        logic     irIn;
        logic     marIn;
        logic     mdrIn;
        logic     yIn;
        logic     zIn;
        logic     hiIn;
        logic     loIn;
        logic     memRead;     // mdr takes memData instead of the bus
        logic     incPc;       // alu forced to bus + 1
        aluOp     op;
    } controlWord;

endpackage

/* datapathTb.sv */
module datapathTb;
    import datapathPkg::*;

    localparam int clockPeriod  = 20;
    localparam int resetCycles  = 3;
    localparam int maxVectors   = 64;
    localparam int lineWords    = 5;    // ctrl, memData, inPort, tag, expected
    localparam int randomChecks = 24;   // three cycles each
    localparam controlWord idleWord = controlWord'(24'h00000d);   // srcNone, opNop

    logic        clock;
    logic        reset;
    controlWord  ctrl;
    dataWord     memData;
    dataWord     inPort;
    dataWord     busValue;
    dataWord     marValue;
    dataWord     irValue;
    dataWord     vecMem [maxVectors * lineWords];
    int          vecCount;
    int          passCount;
    int          failCount;
    int          testChecks;
    int          testFails;
    logic [31:0] randState;

    datapathTop #(
        .resetPc (32'd0)
    ) u_dut (
        .clock    (clock),
        .reset    (reset),
        .ctrl     (ctrl),
        .memData  (memData),
        .inPort   (inPort),
        .busValue (busValue),
        .marValue (marValue),
        .irValue  (irValue)
    );

    always #(clockPeriod / 2) clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // a is the value held in y, b the value on the bus
    function automatic dataWord expectedAlu(input aluOp op, input dataWord a, input dataWord b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opShl:   return b << a[4:0];
            opShr:   return b >> a[4:0];   // zero fill
            opNeg:   return -b;
            opNot:   return ~b;
            default: return '0;
        endcase
    endfunction

    task automatic compareWord(input string name, input dataWord expected,
                               input dataWord actual);
        testChecks++;
        if (actual === expected) begin
            passCount++;
        end else begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            failCount++;
            testFails++;
        end
    endtask

    task automatic compareIr(input dataWord expected, input dataWord actual);
        testChecks++;
        if (actual === expected) begin
            passCount++;
        end else begin
            $display("FAILED at %0t: irValue expected %h (opcode %b), got %h (opcode %b)",
                     $time, expected, expected[31:27], actual, actual[31:27]);
            failCount++;
            testFails++;
        end
    endtask

    task automatic finishTest(input int id);
        $display("test %0d done: %0d checks, %0d failed", id, testChecks, testFails);
        testChecks = 0;
        testFails  = 0;
    endtask

    task automatic driveCycle(input controlWord word, input dataWord mem, input dataWord port);
        @(posedge clock);
        #1;
        ctrl    = word;
        memData = mem;
        inPort  = port;
    endtask

    task automatic replayVectors();
        controlWord word;
        logic [7:0] tag;
        int         base;
        int         lastTest;
        lastTest = 0;
        for (int i = 0; i < vecCount; i++) begin
            base = i * lineWords;
            word = controlWord'(vecMem[base][23:0]);
            tag  = vecMem[base + 3][7:0];
            if (lastTest != 0 && int'(tag[7:4]) != lastTest) begin
                finishTest(lastTest);
            end
            lastTest = int'(tag[7:4]);
            driveCycle(word, vecMem[base + 1], vecMem[base + 2]);
            @(negedge clock);   // bus settled, edge not yet taken
            case (tag[3:0])
                4'd1:    compareWord("busValue", vecMem[base + 4], busValue);
                4'd2:    compareWord("marValue", vecMem[base + 4], marValue);
                4'd3:    compareIr(vecMem[base + 4], irValue);
                default: ;
            endcase
        end
        if (lastTest != 0) begin
            finishTest(lastTest);
        end
    endtask

    task automatic randomAlu();
        aluOp       ops [8];
        aluOp       op;
        controlWord word;
        dataWord    a;
        dataWord    b;
        ops = '{opAdd, opSub, opAnd, opOr, opShl, opShr, opNeg, opNot};
        for (int i = 0; i < randomChecks; i++) begin
            op          = ops[i % 8];
            randState   = xorshift(randState);
            a           = randState;
            randState   = xorshift(randState);
            b           = randState;
            word        = idleWord;
            word.source = srcInPort;
            word.yIn    = 1'b1;
            driveCycle(word, '0, a);   // a into y
            word.yIn    = 1'b0;
            word.zIn    = 1'b1;
            word.op     = op;
            driveCycle(word, '0, b);   // b on the bus, result into z
            word        = idleWord;
            word.source = srcZLow;
            driveCycle(word, '0, '0);
            @(negedge clock);
            compareWord($sformatf("busValue (zLow, %s)", op.name()),
                        expectedAlu(op, a, b), busValue);
        end
        finishTest(7);
    endtask

    initial begin
        int found;
        clock      = 1'b0;
        reset      = 1'b1;
        ctrl       = idleWord;
        memData    = '0;
        inPort     = '0;
        randState  = 32'h3cae;
        passCount  = 0;
        failCount  = 0;
        testChecks = 0;
        testFails  = 0;
        for (int i = 0; i < maxVectors * lineWords; i++) begin
            vecMem[i] = '1;   // end marker, wider than any ctrl word
        end
        $readmemh("datapathVectors.txt", vecMem);
        found = 0;
        while (found < maxVectors && vecMem[found * lineWords] != '1) begin
            found++;
        end
        vecCount = found;   // set once, so the watchdog sees the full count
        repeat (resetCycles) @(posedge clock);
        #1;
        reset = 1'b0;
        if (vecCount == 0) begin
            $display("no vectors could be read from datapathVectors.txt");
            failCount++;
        end else begin
            replayVectors();
            randomAlu();
        end
        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // twice the cycles the vectors and the random phase need
    initial begin
        int limit;
        wait (vecCount > 0);
        limit = (resetCycles + vecCount + 3 * randomChecks) * clockPeriod * 2;
        #(limit);
        $display("timeout: the tests did not finish within %0d time units", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* datapathTop.sv */
module datapathTop #(
    parameter datapathPkg::dataWord resetPc = '0
) (
    input  logic                    clock,
    input  logic                    reset,
    input  datapathPkg::controlWord ctrl,
    input  datapathPkg::dataWord    memData,
    input  datapathPkg::dataWord    inPort,
    output datapathPkg::dataWord    busValue,
    output datapathPkg::dataWord    marValue,
    output datapathPkg::dataWord    irValue
);
    import datapathPkg::*;

    dataWord regValue;    // general register onto the bus mux
    dataWord yValue;      // alu first operand
    wideWord aluResult;   // into z

    registerFile uRegFile (
        .clock    (clock),
        .reset    (reset),
        .ctrl     (ctrl),
        .busValue (busValue),
        .regValue (regValue)
    );

    aluUnit uAlu (
        .yValue   (yValue),
        .busValue (busValue),
        .op       (ctrl.op),
        .incPc    (ctrl.incPc),
        .result   (aluResult)
    );

    transferRegs #(
        .resetPc (resetPc)
    ) uTransfer (
        .clock     (clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .memData   (memData),
        .inPort    (inPort),
        .regValue  (regValue),
        .aluResult (aluResult),
        .busValue  (busValue),
        .yValue    (yValue),
        .marValue  (marValue),
        .irValue   (irValue)
    );

endmodule

/* datapathVectors.txt */
// columns: ctrl memData inPort tag expected, one clock cycle per line
// tag: high digit is the test number, low digit the check (0 none, 1 bus, 2 mar, 3 ir)
// test 1 reset state
00000d 00000000 00000000 11 00000000
20000d 00000000 00000000 11 00000000
14000d 00000000 00000000 11 00000000
000203 00000000 00000000 11 00000000
40000d 00000000 00000000 11 00000000
// test 2 r4 = 9 and r5 = 2 through the mdr, then pc into mar
00084d 00000009 00000000 21 00000000
34800d 00000000 00000000 21 00000009
00084d 00000002 00000000 21 00000000
35800d 00000000 00000000 21 00000002
14000d 00000000 00000000 21 00000009
15000d 00000000 00000000 21 00000002
20100d 00000000 00000000 21 00000000
00000d 00000000 00000000 22 00000000
// test 3 fetch with pc increment and ir load
20122d 00000000 00000000 31 00000000
40484d 80450000 00000000 31 00000001
30200d 00000000 00000000 31 80450000
00000d 00000000 00000000 33 80450000
20100d 00000000 00000000 31 00000001
00000d 00000000 00000000 32 00000001
// test 4 div r4 r5, then -9 by 2 and -9 by 0
14040d 00000000 00000000 41 00000009
150210 00000000 00000000 41 00000002
40008d 00000000 00000000 41 00000004
50010d 00000000 00000000 41 00000001
70000d 00000000 00000000 41 00000004
60000d 00000000 00000000 41 00000001
80040d 00000000 fffffff7 41 fffffff7
150210 00000000 00000000 41 00000002
40000d 00000000 00000000 41 fffffffc
50000d 00000000 00000000 41 ffffffff
000210 00000000 00000000 41 00000000
40000d 00000000 00000000 41 ffffffff
50000d 00000000 00000000 41 fffffff7
// test 5 mul of -3 and 9 into lo and hi
80040d 00000000 fffffffd 51 fffffffd
14020f 00000000 00000000 51 00000009
40008d 00000000 00000000 51 ffffffe5
50010d 00000000 00000000 51 ffffffff
70000d 00000000 00000000 51 ffffffe5
60000d 00000000 00000000 51 ffffffff
// test 6 in-port onto the bus and into r7
87800d 00000000 12345678 61 12345678
17000d 00000000 00000000 61 12345678

/* filelist.f */
datapathPkg.sv
registerFile.sv
aluUnit.sv
transferRegs.sv
datapathTop.sv
datapathTb.sv

/* registerFile.sv */
module registerFile (
    input  logic                    clock,
    input  logic                    reset,
    input  datapathPkg::controlWord ctrl,
    input  datapathPkg::dataWord    busValue,
    output datapathPkg::dataWord    regValue
);
    import datapathPkg::*;

    dataWord regs [16];   // r0 .. r15

    // write port, loads from the bus
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regIn) begin
            regs[ctrl.regSelect] <= busValue;
        end
    end

    // read port feeds the bus mux in transferRegs
    assign regValue = regs[ctrl.regSelect];   // same index as the write

    // A register cannot drive the bus and load from it in one cycle. The
    // bus mux lives in transferRegs, so this ties both modules together.
    regLoopCheck: assert property (@(posedge clock) disable iff (reset)
        !(ctrl.regIn && ctrl.source == srcReg))
        else $error("register %0d drives and loads the bus together", ctrl.regSelect);

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# build the datapath testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

buildLog=build.log
simLog=sim.log

verilator --binary --assert -j 0 --top-module datapathTb -f filelist.f > "$buildLog" 2>&1
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    cat "$buildLog"
    echo "verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/VdatapathTb > "$simLog" 2>&1
simStatus=$?
cat "$simLog"
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Simulation failed" "$simLog"; then
    exit 1
fi
exit 0

/* transferRegs.sv */
module transferRegs #(
    parameter datapathPkg::dataWord resetPc = '0
) (
    input  logic                    clock,
    input  logic                    reset,
    input  datapathPkg::controlWord ctrl,
    input  datapathPkg::dataWord    memData,
    input  datapathPkg::dataWord    inPort,
    input  datapathPkg::dataWord    regValue,
    input  datapathPkg::wideWord    aluResult,
    output datapathPkg::dataWord    busValue,
    output datapathPkg::dataWord    yValue,
    output datapathPkg::dataWord    marValue,
    output datapathPkg::dataWord    irValue
);
    import datapathPkg::*;

    dataWord pcReg;
    dataWord irReg;
    dataWord marReg;
    dataWord mdrReg;
    dataWord yReg;
    wideWord zReg;    // low word quotient or sum, high word remainder
    dataWord hiReg;
    dataWord loReg;

    always_ff @(posedge clock) begin
        if (reset) begin
            pcReg  <= resetPc;
            irReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
            yReg   <= '0;
            zReg   <= '0;
            hiReg  <= '0;
            loReg  <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pcReg <= busValue;
            end
            if (ctrl.irIn) begin
                irReg <= busValue;
            end
            if (ctrl.marIn) begin
                marReg <= busValue;
            end
            if (ctrl.mdrIn) begin
                mdrReg <= ctrl.memRead ? memData : busValue;   // read from memory
            end
            if (ctrl.yIn) begin
                yReg <= busValue;
            end
            if (ctrl.zIn) begin
                zReg <= aluResult;
            end
            if (ctrl.hiIn) begin
                hiReg <= busValue;
            end
            if (ctrl.loIn) begin
                loReg <= busValue;
            end
        end
    end

    // bus multiplexer, exactly one source per cycle
    always_comb begin
        case (ctrl.source)
            srcReg:    busValue = regValue;
            srcPc:     busValue = pcReg;
            srcMdr:    busValue = mdrReg;
            srcZLow:   busValue = zReg[31:0];
            srcZHigh:  busValue = zReg[63:32];
            srcHi:     busValue = hiReg;
            srcLo:     busValue = loReg;
            srcInPort: busValue = inPort;
            default:   busValue = '0;   // srcNone
        endcase
    end

    assign yValue   = yReg;
    assign marValue = marReg;
    assign irValue  = irReg;

    // a memory read without mdrIn would drop the word
    memReadCheck: assert property (@(posedge clock) disable iff (reset)
        ctrl.memRead |-> ctrl.mdrIn)
        else $error("memRead without mdrIn");

    // z must capture a defined alu operation
    zOpCheck: assert property (@(posedge clock) disable iff (reset)
        ctrl.zIn |-> !$isunknown(ctrl.op))
        else $error("zIn with unknown alu op");

endmodule
